// File: Bender.yml
package:
  name: tracker

sources:
  - logic/video_timing_pkg.sv
  - logic/pixel_pkg.sv
  - logic/pipe_delay.sv
  - logic/video_timing_gen.sv
  - logic/fb_address_scaler.sv
  - logic/chroma_threshold.sv
  - logic/center_of_mass.sv
  - logic/crosshair_overlay.sv
  - logic/tracker_top.sv
  - target: simulation
    files:
      - verif/tracker_properties.sv
      - verif/tb_tracker_top.sv

// File: logic/center_of_mass.sv
`timescale 1ns/1ps

module center_of_mass (
    input  logic                      clk_pixel,
    input  logic                      sys_rst_pixel,
    input  video_timing_pkg::hcount_t x,
    input  video_timing_pkg::vcount_t y,
    input  logic                      detect,
    input  logic                      frame_end,
    output video_timing_pkg::hcount_t com_x,
    output video_timing_pkg::vcount_t com_y,
    output logic                      com_valid
);
    import video_timing_pkg::*;

    // count covers every raster position, sums add one coordinate per count
    localparam int count_w = $bits(hcount_t) + $bits(vcount_t);
    localparam int sum_w = count_w + $bits(hcount_t);
    // mean is below the largest coordinate, so the x width bounds both quotients
    localparam int quo_w = $bits(hcount_t);

    typedef logic [sum_w-1:0] sum_t;
    typedef logic [quo_w-1:0] quo_t;
    typedef logic [$clog2(quo_w)-1:0] idx_t;

    // running totals for the frame in progress
    sum_t acc_x;
    sum_t acc_y;
    logic [count_w-1:0] acc_count;

    // divider state, index 0 is x and index 1 is y
    logic busy;
    idx_t bit_idx;
    sum_t den;
    sum_t rem [2];
    quo_t quo [2];

    logic ge [2];
    sum_t rem_next [2];
    quo_t quo_next [2];

    always_ff @(posedge clk_pixel) begin
        if (sys_rst_pixel) begin
            acc_x <= '0;
            acc_y <= '0;
            acc_count <= '0;
        end else if (frame_end) begin
            // totals move into the divider on this edge
            acc_x <= '0;
            acc_y <= '0;
            acc_count <= '0;
        end else if (detect) begin
            acc_x <= acc_x + sum_t'(x);
            acc_y <= acc_y + sum_t'(y);
            acc_count <= acc_count + 1'b1;
        end
    end

    // one restoring step, both quotients share the shifted divisor
    always_comb begin
        for (int k = 0; k < 2; k++) begin
            ge[k] = rem[k] >= den;
            rem_next[k] = ge[k] ? rem[k] - den : rem[k];
            quo_next[k] = {quo[k][quo_w-2:0], ge[k]};
        end
    end

    // datapath: load on frame end, then msb first
    always_ff @(posedge clk_pixel) begin
        if (busy) begin
            rem[0] <= rem_next[0];
            rem[1] <= rem_next[1];
            quo[0] <= quo_next[0];
            quo[1] <= quo_next[1];
            den <= den >> 1;
        end else if (frame_end) begin
            rem[0] <= acc_x;
            rem[1] <= acc_y;
            quo[0] <= '0;
            quo[1] <= '0;
            den <= sum_t'(acc_count) << (quo_w - 1);
        end
    end

    // control: quo_w steps, result written on the last one
    always_ff @(posedge clk_pixel) begin
        if (sys_rst_pixel) begin
            busy <= 1'b0;
            bit_idx <= '0;
            com_x <= '0;
            com_y <= '0;
            com_valid <= 1'b0;
        end else begin
            com_valid <= 1'b0;
            if (busy) begin
                bit_idx <= bit_idx - 1'b1;
                if (bit_idx == '0) begin
                    busy <= 1'b0;
                    com_x <= quo_next[0];
                    // top bit of the y quotient is always zero
                    com_y <= vcount_t'(quo_next[1]);
                    com_valid <= 1'b1;
                end
            end else if (frame_end && (acc_count != '0)) begin
                // empty frame keeps the old centroid
                busy <= 1'b1;
                bit_idx <= idx_t'(quo_w - 1);
            end
        end
    end

endmodule

// File: logic/chroma_threshold.sv
`timescale 1ns/1ps

module chroma_threshold (
    input  logic                clk_pixel,
    input  logic                sys_rst_pixel,
    input  pixel_pkg::channel_t cr,
    input  pixel_pkg::channel_t lower_bound,
    input  pixel_pkg::channel_t upper_bound,
    input  logic                in_region,
    output logic                detect
);

    logic in_window;

    // inclusive at both ends
    // empty window when lower is above upper
    assign in_window = (cr >= lower_bound) && (cr <= upper_bound);

    // samples from outside the camera frame never count
    always_ff @(posedge clk_pixel) begin
        if (sys_rst_pixel) begin
            detect <= 1'b0;
        end else begin
            detect <= in_region && in_window;
        end
    end

endmodule

// File: logic/crosshair_overlay.sv
`timescale 1ns/1ps

module crosshair_overlay (
    input  logic                      clk_pixel,
    input  logic                      sys_rst_pixel,
    input  video_timing_pkg::hcount_t x,
    input  video_timing_pkg::vcount_t y,
    input  logic                      active,
    input  pixel_pkg::rgb_t           cam_pixel,
    input  video_timing_pkg::hcount_t com_x,
    input  video_timing_pkg::vcount_t com_y,
    output pixel_pkg::rgb_t           pixel_out
);
    import pixel_pkg::*;

    localparam rgb_t white = '{red: 8'hff, green: 8'hff, blue: 8'hff};
    localparam rgb_t black = '{red: 8'h00, green: 8'h00, blue: 8'h00};

    logic on_cross;

    // full-height column and full-width row through the centroid
    assign on_cross = (x == com_x) || (y == com_y);

    always_ff @(posedge clk_pixel) begin
        if (sys_rst_pixel) begin
            pixel_out <= black;
        end else if (!active) begin
            // blanking must stay black
            pixel_out <= black;
        end else if (on_cross) begin
            pixel_out <= white;
        end else begin
            pixel_out <= cam_pixel;
        end
    end

endmodule

// File: logic/fb_address_scaler.sv
`timescale 1ns/1ps

module fb_address_scaler #(
    parameter int fb_width = pixel_pkg::DEFAULT_FB_WIDTH,
    parameter int fb_height = pixel_pkg::DEFAULT_FB_HEIGHT,
    parameter int scale_shift = pixel_pkg::DEFAULT_SCALE_SHIFT
) (
    input  logic                      clk_pixel,
    input  logic                      sys_rst_pixel,
    input  video_timing_pkg::hcount_t hcount,
    input  video_timing_pkg::vcount_t vcount,
    output pixel_pkg::fb_addr_t       fb_addr,
    output logic                      fb_addr_valid
);
    import video_timing_pkg::*;
    import pixel_pkg::*;

    // raster extent covered by the upscaled camera frame
    localparam hcount_t h_limit = hcount_t'(fb_width << scale_shift);
    localparam vcount_t v_limit = vcount_t'(fb_height << scale_shift);

    fb_addr_t col_scaled;
    fb_addr_t row_scaled;
    fb_addr_t addr_next;
    logic in_window;

    always_comb begin
        col_scaled = fb_addr_t'(hcount >> scale_shift);
        row_scaled = fb_addr_t'(vcount >> scale_shift);
        // camera faces the viewer, so columns run right to left
        addr_next = fb_addr_t'(fb_width - 1) - col_scaled
                  + fb_addr_t'(fb_width) * row_scaled;
        in_window = (hcount < h_limit) && (vcount < v_limit);
    end

    // address is garbage outside the window, valid flag says so
    always_ff @(posedge clk_pixel) begin
        fb_addr <= addr_next;
        if (sys_rst_pixel) begin
            fb_addr_valid <= 1'b0;
        end else begin
            fb_addr_valid <= in_window;
        end
    end

endmodule

// File: logic/pipe_delay.sv
`timescale 1ns/1ps

module pipe_delay #(
    parameter type payload_t = logic,
    parameter int depth = 1
) (
    input  logic     clk_pixel,
    input  logic     sys_rst_pixel,
    input  payload_t din,
    output payload_t dout
);

    // stage 0 takes din, last stage drives dout
    payload_t stages [depth];

    always_ff @(posedge clk_pixel) begin
        if (sys_rst_pixel) begin
            for (int i = 0; i < depth; i++) begin
                stages[i] <= '0;
            end
        end else begin
            stages[0] <= din;
            for (int i = 1; i < depth; i++) begin
                stages[i] <= stages[i-1];
            end
        end
    end

    assign dout = stages[depth-1];

endmodule

// File: logic/pixel_pkg.sv
package pixel_pkg;

    // one 8-bit colour or chroma channel
    typedef logic [7:0] channel_t;

    // packed pixel, red in the top byte
    typedef struct packed {
        channel_t red;
        channel_t green;
        channel_t blue;
    } rgb_t;

    // 320 x 180 camera frame needs 16 address bits
    typedef logic [15:0] fb_addr_t;

    // camera frame geometry
    localparam int DEFAULT_FB_WIDTH = 320;
    localparam int DEFAULT_FB_HEIGHT = 180;

    // 4x upscale from camera frame to raster
    localparam int DEFAULT_SCALE_SHIFT = 2;

endpackage

// File: logic/tracker_top.sv
`timescale 1ns/1ps

module tracker_top #(
    parameter int h_active = video_timing_pkg::DEFAULT_H_ACTIVE,
    parameter int h_front = video_timing_pkg::DEFAULT_H_FRONT,
    parameter int h_sync = video_timing_pkg::DEFAULT_H_SYNC,
    parameter int h_back = video_timing_pkg::DEFAULT_H_BACK,
    parameter int v_active = video_timing_pkg::DEFAULT_V_ACTIVE,
    parameter int v_front = video_timing_pkg::DEFAULT_V_FRONT,
    parameter int v_sync = video_timing_pkg::DEFAULT_V_SYNC,
    parameter int v_back = video_timing_pkg::DEFAULT_V_BACK,
    parameter int fb_width = pixel_pkg::DEFAULT_FB_WIDTH,
    parameter int fb_height = pixel_pkg::DEFAULT_FB_HEIGHT,
    parameter int scale_shift = pixel_pkg::DEFAULT_SCALE_SHIFT,
    // frame buffer read latency, at least one cycle
    parameter int fb_read_latency = 2
) (
    input  logic                      clk_pixel,
    input  logic                      sys_rst_pixel,
    output pixel_pkg::fb_addr_t       fb_addr,
    output logic                      fb_addr_valid,
    input  pixel_pkg::rgb_t           fb_pixel,
    input  pixel_pkg::channel_t       fb_cr,
    input  pixel_pkg::channel_t       threshold_lower,
    input  pixel_pkg::channel_t       threshold_upper,
    output video_timing_pkg::hcount_t com_x,
    output video_timing_pkg::vcount_t com_y,
    output logic                      com_valid,
    output pixel_pkg::rgb_t           pixel_out,
    output logic                      hsync_out,
    output logic                      vsync_out,
    output logic                      active_out
);
    import video_timing_pkg::*;

    typedef struct packed {
        hcount_t x;
        vcount_t y;
    } coord_t;

    // generator outputs, cycle t
    hcount_t hcount;
    vcount_t vcount;
    logic hsync;
    logic vsync;
    logic active;
    logic new_frame;

    sync_bundle_t sync_gen;
    coord_t coord_gen;
    // t+1+L, alongside the returning frame buffer data
    sync_bundle_t sync_ovl;
    coord_t coord_ovl;
    logic region;
    // t+2+L, alongside detect and pixel_out
    sync_bundle_t sync_out;
    coord_t coord_com;
    logic frame_end;
    logic detect;

    assign sync_gen = '{hsync: hsync, vsync: vsync, active: active};
    assign coord_gen = '{x: hcount, y: vcount};

    video_timing_gen #(
        .h_active(h_active),
        .h_front(h_front),
        .h_sync(h_sync),
        .h_back(h_back),
        .v_active(v_active),
        .v_front(v_front),
        .v_sync(v_sync),
        .v_back(v_back)
    ) timing_gen (
        .clk_pixel(clk_pixel),
        .sys_rst_pixel(sys_rst_pixel),
        .hcount(hcount),
        .vcount(vcount),
        .hsync(hsync),
        .vsync(vsync),
        .active(active),
        .new_frame(new_frame)
    );

    fb_address_scaler #(
        .fb_width(fb_width),
        .fb_height(fb_height),
        .scale_shift(scale_shift)
    ) addr_scaler (
        .clk_pixel(clk_pixel),
        .sys_rst_pixel(sys_rst_pixel),
        .hcount(hcount),
        .vcount(vcount),
        .fb_addr(fb_addr),
        .fb_addr_valid(fb_addr_valid)
    );

    // valid flag is already one cycle in, the read adds L more
    pipe_delay #(.payload_t(logic), .depth(fb_read_latency)) region_delay (
        .clk_pixel(clk_pixel),
        .sys_rst_pixel(sys_rst_pixel),
        .din(fb_addr_valid),
        .dout(region)
    );

    // sync and coordinates: 1+L to the overlay, one more stage to the outputs
    pipe_delay #(.payload_t(sync_bundle_t), .depth(1 + fb_read_latency)) sync_delay_ovl (
        .clk_pixel(clk_pixel),
        .sys_rst_pixel(sys_rst_pixel),
        .din(sync_gen),
        .dout(sync_ovl)
    );

    pipe_delay #(.payload_t(sync_bundle_t), .depth(1)) sync_delay_out (
        .clk_pixel(clk_pixel),
        .sys_rst_pixel(sys_rst_pixel),
        .din(sync_ovl),
        .dout(sync_out)
    );

    pipe_delay #(.payload_t(coord_t), .depth(1 + fb_read_latency)) coord_delay_ovl (
        .clk_pixel(clk_pixel),
        .sys_rst_pixel(sys_rst_pixel),
        .din(coord_gen),
        .dout(coord_ovl)
    );

    pipe_delay #(.payload_t(coord_t), .depth(1)) coord_delay_com (
        .clk_pixel(clk_pixel),
        .sys_rst_pixel(sys_rst_pixel),
        .din(coord_ovl),
        .dout(coord_com)
    );

    // frame end lines up with the last detect of the frame
    pipe_delay #(.payload_t(logic), .depth(2 + fb_read_latency)) frame_delay (
        .clk_pixel(clk_pixel),
        .sys_rst_pixel(sys_rst_pixel),
        .din(new_frame),
        .dout(frame_end)
    );

    chroma_threshold cr_threshold (
        .clk_pixel(clk_pixel),
        .sys_rst_pixel(sys_rst_pixel),
        .cr(fb_cr),
        .lower_bound(threshold_lower),
        .upper_bound(threshold_upper),
        .in_region(region),
        .detect(detect)
    );

    center_of_mass com_calc (
        .clk_pixel(clk_pixel),
        .sys_rst_pixel(sys_rst_pixel),
        .x(coord_com.x),
        .y(coord_com.y),
        .detect(detect),
        .frame_end(frame_end),
        .com_x(com_x),
        .com_y(com_y),
        .com_valid(com_valid)
    );

    crosshair_overlay overlay (
        .clk_pixel(clk_pixel),
        .sys_rst_pixel(sys_rst_pixel),
        .x(coord_ovl.x),
        .y(coord_ovl.y),
        .active(sync_ovl.active),
        .cam_pixel(fb_pixel),
        .com_x(com_x),
        .com_y(com_y),
        .pixel_out(pixel_out)
    );

    assign hsync_out = sync_out.hsync;
    assign vsync_out = sync_out.vsync;
    assign active_out = sync_out.active;

endmodule

// File: logic/video_timing_gen.sv
`timescale 1ns/1ps

module video_timing_gen #(
    parameter int h_active = video_timing_pkg::DEFAULT_H_ACTIVE,
    parameter int h_front = video_timing_pkg::DEFAULT_H_FRONT,
    parameter int h_sync = video_timing_pkg::DEFAULT_H_SYNC,
    parameter int h_back = video_timing_pkg::DEFAULT_H_BACK,
    parameter int v_active = video_timing_pkg::DEFAULT_V_ACTIVE,
    parameter int v_front = video_timing_pkg::DEFAULT_V_FRONT,
    parameter int v_sync = video_timing_pkg::DEFAULT_V_SYNC,
    parameter int v_back = video_timing_pkg::DEFAULT_V_BACK
) (
    input  logic                      clk_pixel,
    input  logic                      sys_rst_pixel,
    output video_timing_pkg::hcount_t hcount,
    output video_timing_pkg::vcount_t vcount,
    output logic                      hsync,
    output logic                      vsync,
    output logic                      active,
    output logic                      new_frame
);
    import video_timing_pkg::*;

    // interval edges, counted from the first active pixel
    localparam hcount_t h_sync_start = hcount_t'(h_active + h_front);
    localparam hcount_t h_sync_end = hcount_t'(h_active + h_front + h_sync);
    localparam hcount_t h_last = hcount_t'(h_active + h_front + h_sync + h_back - 1);
    localparam hcount_t h_blank = hcount_t'(h_active);

    localparam vcount_t v_sync_start = vcount_t'(v_active + v_front);
    localparam vcount_t v_sync_end = vcount_t'(v_active + v_front + v_sync);
    localparam vcount_t v_last = vcount_t'(v_active + v_front + v_sync + v_back - 1);
    localparam vcount_t v_blank = vcount_t'(v_active);

    // raster scan, line counter steps on every line wrap
    always_ff @(posedge clk_pixel) begin
        if (sys_rst_pixel) begin
            hcount <= '0;
            vcount <= '0;
        end else if (hcount == h_last) begin
            hcount <= '0;
            if (vcount == v_last) begin
                vcount <= '0;
            end else begin
                vcount <= vcount + 1'b1;
            end
        end else begin
            hcount <= hcount + 1'b1;
        end
    end

    // flags decoded straight from the counters, same cycle as the position
    always_comb begin
        hsync = (hcount >= h_sync_start) && (hcount < h_sync_end);
        vsync = (vcount >= v_sync_start) && (vcount < v_sync_end);
        active = (hcount < h_blank) && (vcount < v_blank);
        // first blank pixel after the last active line
        new_frame = (hcount == h_blank) && (vcount == v_blank);
    end

endmodule

// File: logic/video_timing_pkg.sv
package video_timing_pkg;

    // raster position, wide enough for a 720p line and frame
    typedef logic [10:0] hcount_t;
    typedef logic [9:0] vcount_t;

    // 720p horizontal timing, in pixels
    localparam int DEFAULT_H_ACTIVE = 1280;
    localparam int DEFAULT_H_FRONT = 110;
    localparam int DEFAULT_H_SYNC = 40;
    localparam int DEFAULT_H_BACK = 220;

    // 720p vertical timing, in lines
    localparam int DEFAULT_V_ACTIVE = 720;
    localparam int DEFAULT_V_FRONT = 5;
    localparam int DEFAULT_V_SYNC = 5;
    localparam int DEFAULT_V_BACK = 20;

    // sync and blanking flags that travel down the pipeline together
    typedef struct packed {
        logic hsync;
        logic vsync;
        logic active;
    } sync_bundle_t;

endpackage

// File: tracker.f
logic/video_timing_pkg.sv
logic/pixel_pkg.sv
logic/pipe_delay.sv
logic/video_timing_gen.sv
logic/fb_address_scaler.sv
logic/chroma_threshold.sv
logic/center_of_mass.sv
logic/crosshair_overlay.sv
logic/tracker_top.sv
verif/tracker_properties.sv
verif/tb_tracker_top.sv

// File: verif/tb_tracker_top.sv
`timescale 1ns/1ps

module tb_tracker_top;
    import video_timing_pkg::*;
    import pixel_pkg::*;

    // small raster so a frame is only 384 cycles
    localparam int h_active = 16;
    localparam int h_front = 2;
    localparam int h_sync = 3;
    localparam int h_back = 3;
    localparam int v_active = 12;
    localparam int v_front = 1;
    localparam int v_sync = 2;
    localparam int v_back = 1;
    localparam int fb_width = 4;
    localparam int fb_height = 3;
    localparam int scale_shift = 2;
    localparam int fb_read_latency = 2;

    localparam int h_total = h_active + h_front + h_sync + h_back;
    localparam int v_total = v_active + v_front + v_sync + v_back;
    localparam int frame_len = h_total * v_total;
    localparam int out_delay = 2 + fb_read_latency;
    localparam int fb_words = fb_width * fb_height;
    localparam int num_frames = 8;
    localparam int com_timeout = 40;
    localparam rgb_t white = 24'hffffff;
    localparam rgb_t black = 24'h000000;

    logic clk_pixel;
    logic sys_rst_pixel;
    fb_addr_t fb_addr;
    logic fb_addr_valid;
    rgb_t fb_pixel;
    channel_t fb_cr;
    channel_t threshold_lower;
    channel_t threshold_upper;
    hcount_t com_x;
    vcount_t com_y;
    logic com_valid;
    rgb_t pixel_out;
    logic hsync_out;
    logic vsync_out;
    logic active_out;

    // frame buffer contents
    rgb_t fb_rgb_mem [fb_words];
    channel_t fb_cr_mem [fb_words];
    // addresses from earlier falling edges with index 0 the newest
    fb_addr_t addr_hist [fb_read_latency];
    logic valid_hist [fb_read_latency];

    logic [31:0] rng_state;
    int errors;
    int checks;
    int threshold_sets;

    tracker_top #(
        .h_active(h_active),
        .h_front(h_front),
        .h_sync(h_sync),
        .h_back(h_back),
        .v_active(v_active),
        .v_front(v_front),
        .v_sync(v_sync),
        .v_back(v_back),
        .fb_width(fb_width),
        .fb_height(fb_height),
        .scale_shift(scale_shift),
        .fb_read_latency(fb_read_latency)
    ) dut (
        .clk_pixel(clk_pixel),
        .sys_rst_pixel(sys_rst_pixel),
        .fb_addr(fb_addr),
        .fb_addr_valid(fb_addr_valid),
        .fb_pixel(fb_pixel),
        .fb_cr(fb_cr),
        .threshold_lower(threshold_lower),
        .threshold_upper(threshold_upper),
        .com_x(com_x),
        .com_y(com_y),
        .com_valid(com_valid),
        .pixel_out(pixel_out),
        .hsync_out(hsync_out),
        .vsync_out(vsync_out),
        .active_out(active_out)
    );

    // 100 ns pixel clock
    initial begin
        clk_pixel = 1'b0;
        forever #50 clk_pixel = ~clk_pixel;
    end

    // lcg step whose upper bits carry the randomness
    function logic [31:0] next_random();
        rng_state = rng_state * 32'd1664525 + 32'd1013904223;
        return rng_state;
    endfunction

    // raster position of cycle k after reset
    function automatic int column_of(int k);
        return k % h_total;
    endfunction

    function automatic int row_of(int k);
        return (k / h_total) % v_total;
    endfunction

    function automatic logic is_visible(int h, int v);
        return (h < h_active) && (v < v_active);
    endfunction

    function automatic logic inside_fb_window(int h, int v);
        return (h < (fb_width << scale_shift)) && (v < (fb_height << scale_shift));
    endfunction

    // camera is mirrored left to right
    function automatic int mirrored_addr(int h, int v);
        return (fb_width - 1 - (h >> scale_shift)) + fb_width * (v >> scale_shift);
    endfunction

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("MISMATCH t=%0t %s got %0h expected %0h", $time, name, got, exp);
        end
    endtask

    task automatic report_failure(input string what);
        errors++;
        $display("ERROR t=%0t %s", $time, what);
    endtask

    // fourth window is empty so that frame must not update
    task automatic pick_thresholds();
        channel_t lo;
        channel_t width;
        threshold_sets++;
        if (threshold_sets == 4) begin
            threshold_lower = 8'd200;
            threshold_upper = 8'd100;
        end else begin
            lo = channel_t'(next_random() >> 24) & 8'h7f;
            width = 8'd64 + (channel_t'(next_random() >> 24) & 8'h3f);
            threshold_lower = lo;
            threshold_upper = lo + width;
        end
    endtask

    initial begin
        int n;
        int q;
        int ph;
        int pv;
        int a;
        int sum_x;
        int sum_y;
        int det_count;
        int exp_cx;
        int exp_cy;
        int model_cx;
        int model_cy;
        int wait_cycles;
        int pulses;
        logic pending;
        logic vsync_prev;
        logic exp_hs;
        logic exp_vs;
        logic exp_act;
        rgb_t exp_pix;
        channel_t cr_val;

        rng_state = 32'he19b;
        errors = 0;
        checks = 0;
        threshold_sets = 0;
        sum_x = 0;
        sum_y = 0;
        det_count = 0;
        exp_cx = 0;
        exp_cy = 0;
        model_cx = 0;
        model_cy = 0;
        wait_cycles = 0;
        pulses = 0;
        pending = 1'b0;
        vsync_prev = 1'b0;

        sys_rst_pixel = 1'b1;
        fb_pixel = '0;
        fb_cr = '0;
        threshold_lower = '0;
        threshold_upper = '0;
        for (int i = 0; i < fb_words; i++) begin
            fb_rgb_mem[i] = rgb_t'(next_random() >> 8);
            fb_cr_mem[i] = channel_t'(next_random() >> 24);
        end
        for (int i = 0; i < fb_read_latency; i++) begin
            addr_hist[i] = '0;
            valid_hist[i] = 1'b0;
        end
        pick_thresholds();

        // two reset cycles and release on a falling edge
        repeat (2) @(posedge clk_pixel);
        @(negedge clk_pixel);
        sys_rst_pixel = 1'b0;

        // one pass per falling edge with n counting cycles since release
        for (n = 0; n < num_frames * frame_len + com_timeout; n++) begin
            if (n > 0) begin
                @(negedge clk_pixel);
            end

            // video outputs trail the generator by 2+L cycles
            q = n - out_delay;
            exp_hs = 1'b0;
            exp_vs = 1'b0;
            exp_act = 1'b0;
            exp_pix = black;
            if (q >= 0) begin
                ph = column_of(q);
                pv = row_of(q);
                exp_hs = (ph >= h_active + h_front) && (ph < h_active + h_front + h_sync);
                exp_vs = (pv >= v_active + v_front) && (pv < v_active + v_front + v_sync);
                exp_act = is_visible(ph, pv);
                if (exp_act) begin
                    // centroid value as it stood one cycle ago
                    if ((ph == model_cx) || (pv == model_cy)) begin
                        exp_pix = white;
                    end else begin
                        exp_pix = fb_rgb_mem[mirrored_addr(ph, pv)];
                    end
                end
            end
            check_value("hsync_out", hsync_out, exp_hs);
            check_value("vsync_out", vsync_out, exp_vs);
            check_value("active_out", active_out, exp_act);
            check_value("pixel_out", pixel_out, exp_pix);

            // address is one cycle behind the raster
            if (n >= 1) begin
                ph = column_of(n - 1);
                pv = row_of(n - 1);
                check_value("fb_addr_valid", fb_addr_valid, inside_fb_window(ph, pv));
                if (inside_fb_window(ph, pv)) begin
                    check_value("fb_addr", fb_addr, mirrored_addr(ph, pv));
                end
            end

            // centroid result with a bounded wait after each frame
            if (com_valid) begin
                if (!pending) begin
                    report_failure("com_valid pulsed with no finished frame holding detections");
                end else begin
                    check_value("com_x", com_x, exp_cx);
                    check_value("com_y", com_y, exp_cy);
                    model_cx = exp_cx;
                    model_cy = exp_cy;
                    pending = 1'b0;
                    pulses++;
                end
            end else if (pending) begin
                wait_cycles++;
                if (wait_cycles > com_timeout) begin
                    report_failure("com_valid did not pulse within 40 cycles of frame end");
                    pending = 1'b0;
                end
            end

            // new window once the frame's sums are latched
            if (vsync_out && !vsync_prev) begin
                pick_thresholds();
            end
            vsync_prev = vsync_out;

            // frame buffer answers the address from L edges back
            a = addr_hist[fb_read_latency-1];
            if (valid_hist[fb_read_latency-1] && (a < fb_words)) begin
                fb_pixel = fb_rgb_mem[a];
                fb_cr = fb_cr_mem[a];
            end else begin
                // junk that the DUT has to ignore
                fb_pixel = rgb_t'(next_random() >> 8);
                fb_cr = channel_t'(next_random() >> 24);
            end
            for (int k = fb_read_latency - 1; k > 0; k--) begin
                addr_hist[k] = addr_hist[k-1];
                valid_hist[k] = valid_hist[k-1];
            end
            addr_hist[0] = fb_addr;
            valid_hist[0] = fb_addr_valid;

            // reference detection for the position whose cr goes in now
            q = n - 1 - fb_read_latency;
            if (q >= 0) begin
                ph = column_of(q);
                pv = row_of(q);
                if (inside_fb_window(ph, pv)) begin
                    cr_val = fb_cr_mem[mirrored_addr(ph, pv)];
                    if ((cr_val >= threshold_lower) && (cr_val <= threshold_upper)) begin
                        sum_x += ph;
                        sum_y += pv;
                        det_count++;
                    end
                end
                // first blank pixel after the last active line
                if ((ph == h_active) && (pv == v_active)) begin
                    if (det_count > 0) begin
                        if (pending) begin
                            report_failure("frame ended before the previous centroid arrived");
                        end
                        pending = 1'b1;
                        wait_cycles = 0;
                        exp_cx = sum_x / det_count;
                        exp_cy = sum_y / det_count;
                    end
                    sum_x = 0;
                    sum_y = 0;
                    det_count = 0;
                end
            end
        end

        if (pending) begin
            report_failure("run ended while a centroid was still outstanding");
        end
        if (pulses < 6) begin
            report_failure("fewer than six centroid updates were seen");
        end
        // failures of the bound centroid assertions
        errors += dut.com_calc.props.failure_count;

        $display("checks %0d errors %0d centroid updates %0d", checks, errors, pulses);
        if (errors == 0) begin
            $display("Finished with no errors");
        end else begin
            $display("Finished with errors");
        end
        $finish;
    end

endmodule

// File: verif/tracker_properties.sv
`timescale 1ns/1ps

module tracker_properties #(
    parameter int h_active = video_timing_pkg::DEFAULT_H_ACTIVE
) (
    input logic                      clk_pixel,
    input logic                      sys_rst_pixel,
    input logic                      com_valid,
    input video_timing_pkg::hcount_t com_x,
    input logic                      frame_end,
    input logic                      busy
);

    // number of assertion failures so far
    int failure_count = 0;

    // result strobe lasts a single cycle
    single_pulse: assert property (@(posedge clk_pixel) disable iff (sys_rst_pixel)
        com_valid |=> !com_valid)
        else begin
            $error("com_valid stayed high for more than one cycle");
            failure_count++;
        end

    // a mean of visible columns stays inside the line
    com_x_in_line: assert property (@(posedge clk_pixel) disable iff (sys_rst_pixel)
        com_valid |-> (com_x < h_active))
        else begin
            $error("com_x is outside the active line while com_valid is high");
            failure_count++;
        end

    // divider has to finish well inside the blanking
    no_overlap: assert property (@(posedge clk_pixel) disable iff (sys_rst_pixel)
        frame_end |-> !busy)
        else begin
            $error("frame_end arrived while the divider was still running");
            failure_count++;
        end

endmodule

// testbench raster is 16 pixels wide
bind center_of_mass tracker_properties #(.h_active(16)) props (
    .clk_pixel(clk_pixel),
    .sys_rst_pixel(sys_rst_pixel),
    .com_valid(com_valid),
    .com_x(com_x),
    .frame_end(frame_end),
    .busy(busy)
);
